/* hw/trace_defines.svh */
`ifndef TRACE_DEFINES_SVH
`define TRACE_DEFINES_SVH

//////////////////////////////////////////////////////////////
// Trace queue sizing
//////////////////////////////////////////////////////////////

// In-flight instructions tracked at once
`define TRACE_DEPTH 8

// Queue index width, log2 of TRACE_DEPTH
`define TRACE_TAG_W 3

// Pointer width with one wrap bit above the index
`define TRACE_PTR_W (`TRACE_TAG_W + 1)

// Width of a cycle stamp, wraps with the free running counter
`define STAMP_W 16

`endif

/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

    //////////////////////////////////////////////////////////////
    // Field types of a 32-bit base instruction
    //////////////////////////////////////////////////////////////

    typedef logic [4:0] reg_idx_t;      // x0 .. x31
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;
    typedef logic [11:0] imm12_t;

    // R-format layout, also gives rd and rs2 for the other formats
    typedef struct packed {
        funct7_t  funct7;
        reg_idx_t rs2;
        reg_idx_t rs1;
        funct3_t  funct3;
        reg_idx_t rd;
        opcode_t  opcode;
    } r_fmt_t;

    // I-format layout, the top twelve bits are the immediate
    typedef struct packed {
        imm12_t   imm12;
        reg_idx_t rs1;
        funct3_t  funct3;
        reg_idx_t rd;
        opcode_t  opcode;
    } i_fmt_t;

    // One fetched word seen through either format
    typedef union packed {
        r_fmt_t r_view;
        i_fmt_t i_view;
    } rv_instr_u;

    //////////////////////////////////////////////////////////////
    // Major opcodes of the I-format instructions
    //////////////////////////////////////////////////////////////

    localparam opcode_t OPC_LOAD   = 7'b0000011;  // lb, lh, lw, lbu, lhu
    localparam opcode_t OPC_OP_IMM = 7'b0010011;  // addi, slti, xori and friends

endpackage

/* hw/trace_types_pkg.sv */
`include "trace_defines.svh"

package trace_types_pkg;

    //////////////////////////////////////////////////////////////
    // Scalar types
    //////////////////////////////////////////////////////////////

    typedef logic [`TRACE_TAG_W-1:0] trace_tag_t;  // Queue entry index
    typedef logic [`STAMP_W-1:0]     stamp_t;      // Cycle count
    typedef logic [2:0]              stall_cnt_t;
    typedef logic [11:0]             operand_t;

    localparam stall_cnt_t STALL_SAT = 3'd7;  // Stall count stops here

    //////////////////////////////////////////////////////////////
    // Per-entry records
    //////////////////////////////////////////////////////////////

    // Cycle on which the instruction entered each stage
    typedef struct packed {
        stamp_t if_cycle;
        stamp_t id_cycle;
        stamp_t ex_cycle;
        stamp_t mem_cycle;
        stamp_t wb_cycle;
    } stage_stamps_t;

    typedef struct packed {
        stall_cnt_t stall_count;   // Decode hold cycles, saturating
        logic       caused_flush;  // Branch redirected the front end
    } hazard_info_t;

    typedef struct packed {
        logic [31:0]           pc;
        rv_isa_pkg::rv_instr_u instr;
    } fetch_info_t;

    // One retired instruction as emitted at the output
    typedef struct packed {
        trace_tag_t           tag;
        fetch_info_t          fetch;
        rv_isa_pkg::reg_idx_t dest;
        operand_t             operand;  // imm12 for I-format, else rs2
        stage_stamps_t        stamps;
        hazard_info_t         hazard;
    } trace_record_t;

endpackage

/* hw/stage_timestamp_log.sv */
`timescale 1ns/100ps

`include "trace_defines.svh"

module stage_timestamp_log (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fetch_stb,
    input  logic                          id_stb,
    input  logic                          ex_stb,
    input  logic                          mem_stb,
    input  logic                          wb_stb,
    input  logic                          flush,
    input  trace_types_pkg::fetch_info_t  fetch_data,
    output trace_types_pkg::trace_tag_t   id_tag,
    output trace_types_pkg::trace_tag_t   ex_tag,
    output trace_types_pkg::trace_tag_t   rd_tag,
    output trace_types_pkg::trace_tag_t   fetch_tag,
    output logic                          id_occupied,
    output logic                          retire_stb,
    output trace_types_pkg::fetch_info_t  fetch_bus,
    output trace_types_pkg::stage_stamps_t stamp_bus
);

    import trace_types_pkg::*;

    typedef logic [`TRACE_PTR_W-1:0] ptr_t;  // Index plus wrap bit

    stamp_t        cycle_cnt;
    ptr_t          if_ptr, id_ptr, ex_ptr, mem_ptr, wb_ptr;
    ptr_t          ex_resume;   // Refetch point after a flush
    ptr_t          id_last;     // Youngest entry that entered decode
    ptr_t          occupancy;
    trace_tag_t    id_wr_tag, mem_tag;
    logic          order_err;

    fetch_info_t   fetch_mem [`TRACE_DEPTH];
    stage_stamps_t stamp_mem [`TRACE_DEPTH];

    //////////////////////////////////////////////////////////////
    // Free running cycle counter and stage pointers
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;  // Wraps
        end
    end

    assign ex_resume = ex_ptr + 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            if_ptr  <= '0;
            id_ptr  <= '0;
            ex_ptr  <= '0;
            mem_ptr <= '0;
            wb_ptr  <= '0;
        end else begin
            // Flush drops everything younger than the branch
            if (flush) begin
                if_ptr <= ex_resume;
                id_ptr <= ex_resume;
            end else begin
                if (fetch_stb) if_ptr <= if_ptr + 1'b1;
                if (id_stb)    id_ptr <= id_ptr + 1'b1;
            end
            if (ex_stb)  ex_ptr  <= ex_ptr + 1'b1;
            if (mem_stb) mem_ptr <= mem_ptr + 1'b1;
            if (wb_stb)  wb_ptr  <= wb_ptr + 1'b1;
        end
    end

    assign id_last     = id_ptr - 1'b1;
    assign fetch_tag   = if_ptr[`TRACE_TAG_W-1:0];
    assign id_wr_tag   = id_ptr[`TRACE_TAG_W-1:0];
    assign id_tag      = id_last[`TRACE_TAG_W-1:0];
    assign ex_tag      = ex_ptr[`TRACE_TAG_W-1:0];   // Entry that ex_stb moves
    assign mem_tag     = mem_ptr[`TRACE_TAG_W-1:0];
    assign rd_tag      = wb_ptr[`TRACE_TAG_W-1:0];
    assign id_occupied = (id_ptr != ex_ptr);         // Decoded, not yet executing
    assign retire_stb  = wb_stb;

    //////////////////////////////////////////////////////////////
    // Entry array, one stamp per stage
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (fetch_stb) begin
            fetch_mem[fetch_tag]          <= fetch_data;
            stamp_mem[fetch_tag].if_cycle <= cycle_cnt;
        end
        if (id_stb) begin
            stamp_mem[id_wr_tag].id_cycle <= cycle_cnt;
        end
        if (ex_stb) begin
            stamp_mem[ex_tag].ex_cycle <= cycle_cnt;
        end
        if (mem_stb) begin
            stamp_mem[mem_tag].mem_cycle <= cycle_cnt;
        end
        if (wb_stb) begin
            stamp_mem[rd_tag].wb_cycle <= cycle_cnt;
        end
    end

    assign fetch_bus = fetch_mem[rd_tag];

    // The write-back stamp lands on this same edge, so pass it around the array
    always_comb begin
        stamp_bus = stamp_mem[rd_tag];
        if (wb_stb) begin
            stamp_bus.wb_cycle = cycle_cnt;
        end
    end

    //////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////

    assign occupancy = if_ptr - wb_ptr;

    // A stage may only take an entry the previous stage already holds
    assign order_err = (id_stb  && (id_ptr  == if_ptr))  ||
                       (ex_stb  && (ex_ptr  == id_ptr))  ||
                       (mem_stb && (mem_ptr == ex_ptr))  ||
                       (wb_stb  && (wb_ptr  == mem_ptr));

    occupancy_bound: assert property (@(posedge clk) disable iff (rst)
        occupancy <= ptr_t'(`TRACE_DEPTH))
        else $error("trace queue holds more than TRACE_DEPTH entries");

    stage_order: assert property (@(posedge clk) disable iff (rst) !order_err)
        else $error("stage strobe overtook the stage before it");

endmodule

/* hw/hazard_event_log.sv */
`timescale 1ns/100ps

`include "trace_defines.svh"

module hazard_event_log (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          stall,
    input  logic                          flush,
    input  logic                          fetch_stb,
    input  logic                          id_occupied,
    input  logic                          retire_stb,
    input  trace_types_pkg::trace_tag_t   id_tag,
    input  trace_types_pkg::trace_tag_t   ex_tag,
    input  trace_types_pkg::trace_tag_t   rd_tag,
    input  trace_types_pkg::trace_tag_t   fetch_tag,
    output trace_types_pkg::hazard_info_t hazard_bus
);

    import trace_types_pkg::*;

    hazard_info_t             haz_mem [`TRACE_DEPTH];
    trace_tag_t               age     [`TRACE_DEPTH];  // Distance past the branch
    trace_tag_t               fetch_age;
    logic [`TRACE_DEPTH-1:0]  clear_vec;
    logic [`TRACE_DEPTH-1:0]  stall_vec;
    logic [`TRACE_DEPTH-1:0]  flush_vec;

    //////////////////////////////////////////////////////////////
    // Per-entry event decode
    //////////////////////////////////////////////////////////////

    assign fetch_age = fetch_tag - ex_tag;

    always_comb begin
        for (int i = 0; i < `TRACE_DEPTH; i++) begin
            age[i] = trace_tag_t'(i) - ex_tag;
            // New fetch, retirement, or younger than a redirecting branch
            clear_vec[i] = (fetch_stb && (fetch_tag == trace_tag_t'(i))) ||
                           (retire_stb && (rd_tag == trace_tag_t'(i))) ||
                           (flush && (age[i] != '0) && (age[i] < fetch_age));
            stall_vec[i] = stall && id_occupied && (id_tag == trace_tag_t'(i));
            flush_vec[i] = flush && (ex_tag == trace_tag_t'(i));
        end
    end

    //////////////////////////////////////////////////////////////
    // Hazard fields
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int i = 0; i < `TRACE_DEPTH; i++) begin
            if (clear_vec[i]) begin
                haz_mem[i] <= '0;
            end else begin
                if (stall_vec[i] && (haz_mem[i].stall_count != STALL_SAT)) begin
                    haz_mem[i].stall_count <= haz_mem[i].stall_count + 1'b1;
                end
                if (flush_vec[i]) begin
                    haz_mem[i].caused_flush <= 1'b1;  // Sticky until reuse
                end
            end
        end
    end

    assign hazard_bus = haz_mem[rd_tag];

    // The redirecting branch must be the entry sitting in decode
    flush_from_decode: assert property (@(posedge clk) disable iff (rst)
        flush |-> (id_occupied && (id_tag == ex_tag)))
        else $error("flush with no matching entry in decode");

endmodule

/* hw/trace_record_builder.sv */
`timescale 1ns/100ps

module trace_record_builder (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           retire_stb,
    input  trace_types_pkg::trace_tag_t    rd_tag,
    input  trace_types_pkg::fetch_info_t   fetch_bus,
    input  trace_types_pkg::stage_stamps_t stamp_bus,
    input  trace_types_pkg::hazard_info_t  hazard_bus,
    output logic                           record_valid,
    output trace_types_pkg::trace_record_t record
);

    import rv_isa_pkg::*;
    import trace_types_pkg::*;

    rv_instr_u     instr;
    logic          is_i_fmt;
    operand_t      operand;
    trace_record_t rec_next;

    //////////////////////////////////////////////////////////////
    // Instruction decode
    //////////////////////////////////////////////////////////////

    assign instr = fetch_bus.instr;

    // Loads and ALU-immediate ops carry imm12 in the top bits
    assign is_i_fmt = (instr.i_view.opcode == OPC_OP_IMM) ||
                      (instr.i_view.opcode == OPC_LOAD);

    assign operand = is_i_fmt ? instr.i_view.imm12
                              : {7'd0, instr.r_view.rs2};  // Zero extend

    always_comb begin
        rec_next.tag     = rd_tag;
        rec_next.fetch   = fetch_bus;
        rec_next.dest    = instr.r_view.rd;  // Same position in both formats
        rec_next.operand = operand;
        rec_next.stamps  = stamp_bus;
        rec_next.hazard  = hazard_bus;
    end

    //////////////////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            record_valid <= 1'b0;
        end else begin
            record_valid <= retire_stb;  // One cycle after wb_stb
        end
    end

    always_ff @(posedge clk) begin
        if (retire_stb) begin
            record <= rec_next;
        end
    end

    // Back to back records come from consecutive queue entries
    records_in_order: assert property (@(posedge clk) disable iff (rst)
        (record_valid && $past(record_valid)) |->
            (record.tag == trace_tag_t'($past(record.tag) + 1'b1)))
        else $error("back to back records skipped a queue entry");

endmodule

/* hw/pipeline_trace_top.sv */
`timescale 1ns/100ps

module pipeline_trace_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           fetch_stb,
    input  trace_types_pkg::fetch_info_t   fetch_data,
    input  logic                           id_stb,
    input  logic                           ex_stb,
    input  logic                           mem_stb,
    input  logic                           wb_stb,
    input  logic                           stall,
    input  logic                           flush,
    output logic                           record_valid,
    output trace_types_pkg::trace_record_t record
);

    import trace_types_pkg::*;

    trace_tag_t    id_tag, ex_tag, rd_tag, fetch_tag;
    logic          id_occupied;
    logic          retire_stb;
    fetch_info_t   fetch_bus;
    stage_stamps_t stamp_bus;
    hazard_info_t  hazard_bus;

    //////////////////////////////////////////////////////////////
    // Stage stamps and hazards side by side, joined at retire
    //////////////////////////////////////////////////////////////

    stage_timestamp_log i_stamp_log (
        .clk         (clk),
        .rst         (rst),
        .fetch_stb   (fetch_stb),
        .id_stb      (id_stb),
        .ex_stb      (ex_stb),
        .mem_stb     (mem_stb),
        .wb_stb      (wb_stb),
        .flush       (flush),
        .fetch_data  (fetch_data),
        .id_tag      (id_tag),
        .ex_tag      (ex_tag),
        .rd_tag      (rd_tag),
        .fetch_tag   (fetch_tag),
        .id_occupied (id_occupied),
        .retire_stb  (retire_stb),
        .fetch_bus   (fetch_bus),
        .stamp_bus   (stamp_bus)
    );

    hazard_event_log i_hazard_log (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .flush       (flush),
        .fetch_stb   (fetch_stb),
        .id_occupied (id_occupied),
        .retire_stb  (retire_stb),
        .id_tag      (id_tag),
        .ex_tag      (ex_tag),
        .rd_tag      (rd_tag),
        .fetch_tag   (fetch_tag),
        .hazard_bus  (hazard_bus)
    );

    trace_record_builder i_builder (
        .clk          (clk),
        .rst          (rst),
        .retire_stb   (retire_stb),
        .rd_tag       (rd_tag),
        .fetch_bus    (fetch_bus),
        .stamp_bus    (stamp_bus),
        .hazard_bus   (hazard_bus),
        .record_valid (record_valid),
        .record       (record)
    );

endmodule

/* sim/tb_pipeline_trace.sv */
`timescale 1ns/100ps

module tb_pipeline_trace;

    import trace_types_pkg::*;

    // One cycle of the case file
    typedef struct packed {
        logic          fetch_stb;
        logic          id_stb;
        logic          ex_stb;
        logic          mem_stb;
        logic          wb_stb;
        logic          stall;
        logic          flush;
        logic [31:0]   pc;
        logic [31:0]   instr;
        logic          rnd;     // Word comes from the LCG
        logic          chk;     // Expected record follows
        trace_tag_t    tag;
        stage_stamps_t stamps;
        hazard_info_t  hazard;
        logic [31:0]   exp_pc;  // Fetch address of the retiring entry
    } case_row_t;

    logic          clk;
    logic          rst;
    logic          fetch_stb, id_stb, ex_stb, mem_stb, wb_stb;
    logic          stall, flush;
    fetch_info_t   fetch_data;
    logic          record_valid;
    trace_record_t record;

    case_row_t     cases [$];
    logic [31:0]   instr_by_pc [logic [31:0]];
    logic [31:0]   lcg_state;
    int            records_checked;

    pipeline_trace_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .fetch_stb    (fetch_stb),
        .fetch_data   (fetch_data),
        .id_stb       (id_stb),
        .ex_stb       (ex_stb),
        .mem_stb      (mem_stb),
        .wb_stb       (wb_stb),
        .stall        (stall),
        .flush        (flush),
        .record_valid (record_valid),
        .record       (record)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    ////////////////////////////////////////////////////////////
    // Reference rules and failure handling
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Loads and ALU-immediate ops report imm12, all others rs2
    function automatic logic [11:0] expected_operand(input logic [31:0] word);
        logic [6:0] opcode;
        opcode = word[6:0];
        if (opcode == 7'h13 || opcode == 7'h03) begin
            return word[31:20];
        end else begin
            return {7'd0, word[24:20]};
        end
    endfunction

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        abort_run();
    endtask

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp) report_mismatch("record_valid", 32'(got), 32'(exp));
    endtask

    task automatic check_stamps(input stage_stamps_t got, input stage_stamps_t exp);
        if (got.if_cycle !== exp.if_cycle)
            report_mismatch("if_cycle", 32'(got.if_cycle), 32'(exp.if_cycle));
        if (got.id_cycle !== exp.id_cycle)
            report_mismatch("id_cycle", 32'(got.id_cycle), 32'(exp.id_cycle));
        if (got.ex_cycle !== exp.ex_cycle)
            report_mismatch("ex_cycle", 32'(got.ex_cycle), 32'(exp.ex_cycle));
        if (got.mem_cycle !== exp.mem_cycle)
            report_mismatch("mem_cycle", 32'(got.mem_cycle), 32'(exp.mem_cycle));
        if (got.wb_cycle !== exp.wb_cycle)
            report_mismatch("wb_cycle", 32'(got.wb_cycle), 32'(exp.wb_cycle));
    endtask

    task automatic check_hazard(input hazard_info_t got, input hazard_info_t exp);
        if (got.stall_count !== exp.stall_count)
            report_mismatch("stall_count", 32'(got.stall_count), 32'(exp.stall_count));
        if (got.caused_flush !== exp.caused_flush)
            report_mismatch("caused_flush", 32'(got.caused_flush), 32'(exp.caused_flush));
    endtask

    task automatic check_record(input trace_record_t got, input trace_record_t exp);
        if (got.tag !== exp.tag)
            report_mismatch("tag", 32'(got.tag), 32'(exp.tag));
        if (got.fetch.pc !== exp.fetch.pc)
            report_mismatch("pc", got.fetch.pc, exp.fetch.pc);
        if (got.fetch.instr !== exp.fetch.instr)
            report_mismatch("instr", got.fetch.instr, exp.fetch.instr);
        if (got.dest !== exp.dest)
            report_mismatch("dest", 32'(got.dest), 32'(exp.dest));
        if (got.operand !== exp.operand)
            report_mismatch("operand", 32'(got.operand), 32'(exp.operand));
        check_stamps(got.stamps, exp.stamps);
        check_hazard(got.hazard, exp.hazard);
    endtask

    ////////////////////////////////////////////////////////////
    // Case file, drive and check
    ////////////////////////////////////////////////////////////

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [20];
        case_row_t   row;
        fd = $fopen("sim/trace_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the case file sim/trace_cases.txt");
            abort_run();
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() < 2 || line[0] == "#") continue;  // Blank or comment
                n = $sscanf(line, "%d %d %d %d %d %d %d %h %h %d %d %d %d %d %d %d %d %d %d %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                            f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18],
                            f[19]);
                if (n != 20) begin
                    $display("Case file line has %0d fields instead of 20: %s", n, line);
                    abort_run();
                end else begin
                    row.fetch_stb          = f[0][0];
                    row.id_stb             = f[1][0];
                    row.ex_stb             = f[2][0];
                    row.mem_stb            = f[3][0];
                    row.wb_stb             = f[4][0];
                    row.stall              = f[5][0];
                    row.flush              = f[6][0];
                    row.pc                 = f[7];
                    row.instr              = f[8];
                    row.rnd                = f[9][0];
                    row.chk                = f[10][0];
                    row.tag                = trace_tag_t'(f[11]);
                    row.stamps.if_cycle    = stamp_t'(f[12]);
                    row.stamps.id_cycle    = stamp_t'(f[13]);
                    row.stamps.ex_cycle    = stamp_t'(f[14]);
                    row.stamps.mem_cycle   = stamp_t'(f[15]);
                    row.stamps.wb_cycle    = stamp_t'(f[16]);
                    row.hazard.stall_count = f[17][2:0];
                    row.hazard.caused_flush = f[18][0];
                    row.exp_pc             = f[19];
                    cases.push_back(row);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_row(input case_row_t row);
        fetch_info_t fi;
        fi.pc    = row.pc;
        fi.instr = row.instr;
        if (row.fetch_stb && row.rnd) begin
            lcg_state = lcg_step(lcg_state);
            fi.instr  = lcg_state;
        end
        if (row.fetch_stb) instr_by_pc[row.pc] = fi.instr;  // Latest word at this pc
        fetch_stb  <= row.fetch_stb;
        id_stb     <= row.id_stb;
        ex_stb     <= row.ex_stb;
        mem_stb    <= row.mem_stb;
        wb_stb     <= row.wb_stb;
        stall      <= row.stall;
        flush      <= row.flush;
        fetch_data <= fi;
    endtask

    task automatic check_outputs(input case_row_t row);
        trace_record_t exp;
        logic [31:0]   word;
        check_valid(record_valid, row.wb_stb);
        if (row.wb_stb && row.chk) begin
            if (!instr_by_pc.exists(row.exp_pc)) begin
                $display("Case file expects a record for pc 0x%0h, never fetched", row.exp_pc);
                abort_run();
            end else begin
                word            = instr_by_pc[row.exp_pc];
                exp.tag         = row.tag;
                exp.fetch.pc    = row.exp_pc;
                exp.fetch.instr = word;
                exp.dest        = word[11:7];  // rd field
                exp.operand     = expected_operand(word);
                exp.stamps      = row.stamps;
                exp.hazard      = row.hazard;
                check_record(record, exp);
                records_checked++;
            end
        end
    endtask

    initial begin : stimulus
        rst             = 1'b1;
        fetch_stb       = 1'b0;
        id_stb          = 1'b0;
        ex_stb          = 1'b0;
        mem_stb         = 1'b0;
        wb_stb          = 1'b0;
        stall           = 1'b0;
        flush           = 1'b0;
        fetch_data      = '0;
        lcg_state       = 32'd24246;
        records_checked = 0;
        load_cases();
        repeat (16) begin
            @(negedge clk);
            check_valid(record_valid, 1'b0);  // Quiet in reset
        end
        @(posedge clk);
        rst <= 1'b0;
        // Row i is sampled on the edge where the counter reads i
        for (int i = 0; i <= cases.size(); i++) begin
            if (i < cases.size()) drive_row(cases[i]);
            else drive_row('0);
            @(negedge clk);
            if (i > 0) check_outputs(cases[i-1]);
            else check_valid(record_valid, 1'b0);
            @(posedge clk);
        end
        if (records_checked == 0) begin
            $display("No record was checked, the case file holds no expected records");
            abort_run();
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

    initial begin : watchdog
        int limit_ns;
        #1;
        limit_ns = (cases.size() + 20) * 40 * 2;  // Cases plus reset, doubled
        #(limit_ns);
        $display("Timeout: the run did not end within %0d ns", limit_ns);
        abort_run();
    end

endmodule

/* sim/trace_cases.txt */
# fe id ex mem wb stall flush pc instr rnd, then chk tag if id ex mem wb stalls flushed exp_pc
# One line per cycle, pc and instr in hex, rnd=1 takes the instruction word from the LCG
1 0 0 0 0 0 0 00001000 12308293 0  0 0  0  0  0  0  0 0 0 00000000
0 1 0 0 0 0 0 00000000 00000000 0  0 0  0  0  0  0  0 0 0 00000000
0 0 1 0 0 0 0 00000000 00000000 0  0 0  0  0  0  0  0 0 0 00000000
0 0 0 1 0 0 0 00000000 00000000 0  0 0  0  0  0  0  0 0 0 00000000
0 0 0 0 1 0 0 00000000 00000000 0  1 0  0  1  2  3  4 0 0 00001000
1 0 0 0 0 0 0 00001004 00000000 1  0 0  0  0  0  0  0 0 0 00000000
1 1 0 0 0 0 0 00001008 003103b3 0  0 0  0  0  0  0  0 0 0 00000000
1 1 1 0 0 0 0 0000100c 7f022483 0  0 0  0  0  0  0  0 0 0 00000000
0 1 1 1 0 0 0 00000000 00000000 0  0 0  0  0  0  0  0 0 0 00000000
0 0 1 1 1 0 0 00000000 00000000 0  1 1  5  6  7  8  9 0 0 00001004
0 0 0 1 1 0 0 00000000 00000000 0  1 2  6  7  8  9 10 0 0 00001008
0 0 0 0 1 0 0 00000000 00000000 0  1 3  7  8  9 10 11 0 0 0000100c
1 0 0 0 0 0 0 00001010 00000000 1  0 0  0  0  0  0  0 0 0 00000000
0 1 0 0 0 0 0 00000000 00000000 0  0 0  0  0  0  0  0 0 0 00000000
0 0 0 0 0 1 0 00000000 00000000 0  0 0  0  0  0  0  0 0 0 00000000
0 0 0 0 0 1 0 00000000 00000000 0  0 0  0  0  0  0  0 0 0 00000000
0 0 0 0 0 1 0 00000000 00000000 0  0 0  0  0  0  0  0 0 0 00000000
0 0 0 0 0 1 0 00000000 00000000 0  0 0  0  0  0  0  0 0 0 00000000
0 0 0 0 0 1 0 00000000 00000000 0  0 0  0  0  0  0  0 0 0 00000000
0 0 0 0 0 1 0 00000000 00000000 0  0 0  0  0  0  0  0 0 0 00000000
0 0 0 0 0 1 0 00000000 00000000 0  0 0  0  0  0  0  0 0 0 00000000
0 0 0 0 0 1 0 00000000 00000000 0  0 0  0  0  0  0  0 0 0 00000000
0 0 0 0 0 1 0 00000000 00000000 0  0 0  0  0  0  0  0 0 0 00000000
0 0 0 0 0 1 0 00000000 00000000 0  0 0  0  0  0  0  0 0 0 00000000
1 0 1 0 0 0 0 00001014 00000000 1  0 0  0  0  0  0  0 0 0 00000000
0 1 0 1 0 0 0 00000000 00000000 0  0 0  0  0  0  0  0 0 0 00000000
0 0 0 0 1 1 0 00000000 00000000 0  1 4 12 13 24 25 26 7 0 00001010
0 0 0 0 0 1 0 00000000 00000000 0  0 0  0  0  0  0  0 0 0 00000000
0 0 0 0 0 1 0 00000000 00000000 0  0 0  0  0  0  0  0 0 0 00000000
0 0 1 0 0 0 0 00000000 00000000 0  0 0  0  0  0  0  0 0 0 00000000
0 0 0 1 0 0 0 00000000 00000000 0  0 0  0  0  0  0  0 0 0 00000000
0 0 0 0 1 0 0 00000000 00000000 0  1 5 24 25 29 30 31 3 0 00001014
1 0 0 0 0 0 0 00001018 00208463 0  0 0  0  0  0  0  0 0 0 00000000
1 1 0 0 0 0 0 0000101c 00000000 1  0 0  0  0  0  0  0 0 0 00000000
1 0 0 0 0 0 0 00001020 00000000 1  0 0  0  0  0  0  0 0 0 00000000
0 0 1 0 0 0 1 00000000 00000000 0  0 0  0  0  0  0  0 0 0 00000000
1 0 0 1 0 0 0 00002000 fff54513 0  0 0  0  0  0  0  0 0 0 00000000
1 1 0 0 1 0 0 00002004 00000000 1  1 6 32 33 35 36 37 0 1 00001018
0 1 1 0 0 0 0 00000000 00000000 0  0 0  0  0  0  0  0 0 0 00000000
0 0 1 1 0 0 0 00000000 00000000 0  0 0  0  0  0  0  0 0 0 00000000
0 0 0 1 1 0 0 00000000 00000000 0  1 7 36 37 38 39 40 0 0 00002000
0 0 0 0 1 0 0 00000000 00000000 0  1 0 37 38 39 40 41 0 0 00002004
0 0 0 0 0 0 0 00000000 00000000 0  0 0  0  0  0  0  0 0 0 00000000
0 0 0 0 0 0 0 00000000 00000000 0  0 0  0  0  0  0  0 0 0 00000000

/* build.f */
+incdir+hw
hw/rv_isa_pkg.sv
hw/trace_types_pkg.sv
hw/stage_timestamp_log.sv
hw/hazard_event_log.sv
hw/trace_record_builder.sv
hw/pipeline_trace_top.sv
sim/tb_pipeline_trace.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_pipeline_trace \
    -f build.f -o tb_pipeline_trace

output=$(./obj_dir/tb_pipeline_trace 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Simulation finished: PASS"; then
    exit 0
else
    exit 1
fi
